// File: rtl/rename_pkg.sv
package rename_pkg;

   // ============================================================
   // Register and checkpoint sizes
   // ============================================================
   localparam int AREGS  = 8;                      // Architectural registers
   localparam int AREG_W = $clog2(AREGS);          // Width of an architectural index
   localparam int PREG_W = 6;                      // Width of a physical register number
   localparam int NCHECK = 16;                     // Checkpoint rows in the RAM
   localparam int CHK_W  = $clog2(NCHECK);         // Width of a checkpoint id
   localparam int FREE_W = $clog2(NCHECK + 1);     // Free count must reach NCHECK itself
   localparam int ROW_W  = AREGS * PREG_W;         // One saved map row, 48 bits

   // ============================================================
   // Bus address map
   // ============================================================
   localparam int ADR_W          = 8;              // Wishbone address width
   localparam int DAT_W          = 16;             // Wishbone data width
   localparam int OP_LSB         = 4;              // Op code sits in adr[7:4]
   localparam int PATCH_LANE_LSB = 8;              // Patch lane sits in dat_i[10:8]

   typedef logic [PREG_W-1:0] preg_t;
   typedef logic [AREG_W-1:0] areg_t;
   typedef logic [CHK_W-1:0]  chk_t;

   // Lane i holds the physical register of architectural register i
   typedef preg_t [AREGS-1:0] map_row_t;

   // Operation codes, writes first and reads from 8 upward
   typedef enum logic [3:0] {
      OP_RENAME  = 4'd0,
      OP_SAVE    = 4'd1,
      OP_PATCH   = 4'd2,
      OP_RESTORE = 4'd3,
      OP_RELEASE = 4'd4,
      OP_MAP     = 4'd8,
      OP_LASTID  = 4'd9,
      OP_FREE    = 4'd10
   } op_t;

endpackage

// File: rtl/checkpoint_ram.sv
module checkpoint_ram import rename_pkg::*; (
   input  logic             clka,
   input  logic             ena,    // Write port enable
   input  logic [AREGS-1:0] wea,    // One enable per architectural lane
   input  chk_t             addra,  // Row being written
   input  map_row_t         dina,
   input  chk_t             addrb,  // Row being read
   output map_row_t         doutb
);

   // ============================================================
   // Storage
   // ============================================================

   // Flat rows so that each lane can be sliced out by its bit offset
   logic [ROW_W-1:0] mem [NCHECK];

   // Every checkpoint row powers up as all zeros
   initial begin
      for (int r = 0; r < NCHECK; r++) begin
         mem[r] = '0;
      end
   end

   // ============================================================
   // Write port
   // ============================================================

   // Each lane has its own enable so a patch touches just one preg field
   always_ff @(posedge clka) begin
      for (int i = 0; i < AREGS; i++) begin
         if (ena && wea[i]) begin
            mem[addra][i*PREG_W +: PREG_W] <= dina[i];   // Lane i only
         end
      end
   end

   // ============================================================
   // Read port
   // ============================================================

   // Distributed RAM read is asynchronous, so the row is there in the
   // same cycle that addrb is presented
   assign doutb = map_row_t'(mem[addrb]);

endmodule

// File: rtl/rename_map.sv
module rename_map import rename_pkg::*; (
   input  logic     clka,
   input  logic     reset,
   input  logic     ren_en,       // Single lane rename
   input  areg_t    ren_areg,     // Lane being renamed
   input  preg_t    ren_preg,     // New physical register for that lane
   input  logic     rst_en,       // Whole map restore from a checkpoint
   input  map_row_t restore_row,  // Checkpoint row read from the RAM
   output map_row_t map_row       // Current map, all lanes at once
);

   // ============================================================
   // Current map table
   // ============================================================

   // The table is eight preg registers held as one packed row. The row
   // goes straight to the RAM write data for a save and to the bus read
   // mux, so no separate output stage is needed

   always_ff @(posedge clka) begin
      if (reset) begin
         // Identity map out of reset, areg i lives in preg i
         for (int i = 0; i < AREGS; i++) begin
            map_row[i] <= preg_t'(i);
         end
      end
      else if (rst_en) begin
         map_row <= restore_row;             // All lanes replaced at once
      end
      else if (ren_en) begin
         map_row[ren_areg] <= ren_preg;      // Only the named lane changes
      end
   end

   // The slave never asks for a restore and a rename on the same edge.
   // If it ever did, the restore wins since it describes an older and
   // complete state of the machine

endmodule

// File: rtl/checkpoint_alloc.sv
module checkpoint_alloc import rename_pkg::*; (
   input  logic              clka,
   input  logic              reset,
   input  logic              alloc_req,  // Take the lowest free id
   input  logic              rel_req,    // Give back rel_id
   input  chk_t              rel_id,
   output chk_t              alloc_id,   // Lowest free id, valid when not full
   output logic              full,       // No free id left
   output logic [NCHECK-1:0] busy_vec,   // One bit per id, set means in use
   output logic [FREE_W-1:0] free_cnt    // Number of free ids
);

   logic [NCHECK-1:0] alloc_mask;        // One-hot of the id being taken
   logic [NCHECK-1:0] rel_mask;          // One-hot of the id being freed

   // ============================================================
   // Lowest free id
   // ============================================================

   // Scan from the top down so the last hit is the lowest free id
   always_comb begin
      alloc_id = '0;
      for (int i = NCHECK - 1; i >= 0; i--) begin
         if (!busy_vec[i]) begin
            alloc_id = chk_t'(i);
         end
      end
   end

   assign full = &busy_vec;               // Every id is in use

   // Count of zero bits in the bitmap
   always_comb begin
      free_cnt = '0;
      for (int i = 0; i < NCHECK; i++) begin
         free_cnt = free_cnt + FREE_W'(!busy_vec[i]);
      end
   end

   // ============================================================
   // Bitmap update
   // ============================================================

   assign alloc_mask = (alloc_req && !full) ? (NCHECK'(1) << alloc_id) : '0;
   assign rel_mask   = rel_req ? (NCHECK'(1) << rel_id) : '0;

   always_ff @(posedge clka) begin
      if (reset) begin
         busy_vec <= '0;                                 // All ids free
      end
      else begin
         busy_vec <= (busy_vec | alloc_mask) & ~rel_mask; // Set then clear
      end
   end

endmodule

// File: rtl/rename_wb_slave.sv
module rename_wb_slave import rename_pkg::*; (
   input  logic              clka,
   input  logic              reset,
   // Wishbone classic slave
   input  logic              cyc,
   input  logic              stb,
   input  logic              we,
   input  logic [ADR_W-1:0]  adr,
   input  logic [DAT_W-1:0]  dat_i,
   output logic [DAT_W-1:0]  dat_o,
   output logic              ack,
   output logic              err,
   // Status from the map and the allocator
   input  map_row_t          map_row,
   input  chk_t              alloc_id,
   input  logic              full,
   input  logic [NCHECK-1:0] busy_vec,
   input  logic [FREE_W-1:0] free_cnt,
   // Map controls
   output logic              ren_en,
   output areg_t             ren_areg,
   output preg_t             ren_preg,
   output logic              rst_en,
   // Allocator controls
   output logic              alloc_req,
   output logic              rel_req,
   output chk_t              rel_id,
   // Checkpoint RAM controls
   output logic              ena,
   output logic [AREGS-1:0]  wea,
   output chk_t              addra,
   output map_row_t          dina,
   output chk_t              addrb
);

   op_t              op;         // Decoded op code
   chk_t             adr_id;     // Checkpoint id carried in the address
   areg_t            lane;       // Patch lane from the data
   logic             start;      // New transfer this cycle
   logic             bad;        // Transfer must end with err
   logic             go;         // Legal transfer, commit on this edge
   logic [DAT_W-1:0] rd_data;    // Read value before the output register
   map_row_t         patch_row;  // Patch preg placed in its lane
   chk_t             last_id;    // Id of the most recent save

   // ============================================================
   // Decode
   // ============================================================

   assign start  = cyc && stb && !ack && !err;      // Idle bus with a strobe
   assign op     = op_t'(adr[OP_LSB +: 4]);
   assign adr_id = adr[CHK_W-1:0];
   assign lane   = dat_i[PATCH_LANE_LSB +: AREG_W];

   // Legality check and read mux, one arm per op code
   always_comb begin
      bad     = 1'b0;
      rd_data = '0;
      case (op)
         OP_RENAME, OP_PATCH: bad = !we;
         OP_SAVE:             bad = !we || full;                  // No id to hand out
         OP_RESTORE,
         OP_RELEASE:          bad = !we || !busy_vec[adr_id];     // Id must be in use
         OP_MAP: begin
            bad     = we;
            rd_data = DAT_W'(map_row[adr[AREG_W-1:0]]);
         end
         OP_LASTID: begin
            bad     = we;
            rd_data = DAT_W'(last_id);
         end
         OP_FREE: begin
            bad     = we;
            rd_data = DAT_W'(free_cnt);
         end
         default:             bad = 1'b1;                         // Unknown op code
      endcase
   end

   assign go = start && !bad;   // Nothing moves on an err transfer

   // ============================================================
   // Enables, one group per op and only on the committing edge
   // ============================================================

   assign ren_en    = go && (op == OP_RENAME);
   assign rst_en    = go && (op == OP_RESTORE);
   assign alloc_req = go && (op == OP_SAVE);
   assign rel_req   = go && (op == OP_RESTORE || op == OP_RELEASE);  // A restore frees its id
   assign ena       = go && (op == OP_SAVE || op == OP_PATCH);

   assign ren_areg = adr[AREG_W-1:0];
   assign ren_preg = dat_i[PREG_W-1:0];
   assign rel_id   = adr_id;
   assign addrb    = adr_id;    // Restore reads the row asynchronously

   // Patch data carries the new preg in its own lane only
   always_comb begin
      patch_row       = '0;
      patch_row[lane] = dat_i[PREG_W-1:0];
   end

   // A save writes the whole current map, a patch writes a single lane
   assign wea   = !ena ? '0 : (op == OP_SAVE) ? '1 : (AREGS'(1) << lane);
   assign addra = (op == OP_SAVE) ? alloc_id : adr_id;
   assign dina  = (op == OP_SAVE) ? map_row : patch_row;

   // ============================================================
   // Response registers
   // ============================================================

   always_ff @(posedge clka) begin
      if (reset) begin
         ack     <= 1'b0;
         err     <= 1'b0;
         last_id <= '0;
      end
      else begin
         ack <= go;                  // High for exactly one cycle
         err <= start && bad;
         if (alloc_req) begin
            last_id <= alloc_id;     // Same id the RAM row lands in
         end
      end
   end

   // Read data is captured with ack and held until the next transfer
   always_ff @(posedge clka) begin
      if (start) begin
         dat_o <= rd_data;
      end
   end

endmodule

// File: rtl/rename_top.sv
module rename_top import rename_pkg::*; (
   input  logic             clka,
   input  logic             reset,
   input  logic             cyc,
   input  logic             stb,
   input  logic             we,
   input  logic [ADR_W-1:0] adr,
   input  logic [DAT_W-1:0] dat_i,
   output logic [DAT_W-1:0] dat_o,
   output logic             ack,
   output logic             err
);

   // ============================================================
   // Internal wiring
   // ============================================================

   map_row_t          map_row;     // Current map
   map_row_t          doutb;       // Checkpoint row being restored
   chk_t              alloc_id;
   logic              full;
   logic [NCHECK-1:0] busy_vec;
   logic [FREE_W-1:0] free_cnt;
   logic              ren_en;
   areg_t             ren_areg;
   preg_t             ren_preg;
   logic              rst_en;
   logic              alloc_req;
   logic              rel_req;
   chk_t              rel_id;
   logic              ena;
   logic [AREGS-1:0]  wea;
   chk_t              addra;
   map_row_t          dina;
   chk_t              addrb;

   // Bus decode and sequencing
   rename_wb_slave u_slave (
      .clka      (clka),      .reset     (reset),
      .cyc       (cyc),       .stb       (stb),
      .we        (we),        .adr       (adr),
      .dat_i     (dat_i),     .dat_o     (dat_o),
      .ack       (ack),       .err       (err),
      .map_row   (map_row),   .alloc_id  (alloc_id),
      .full      (full),      .busy_vec  (busy_vec),
      .free_cnt  (free_cnt),  .ren_en    (ren_en),
      .ren_areg  (ren_areg),  .ren_preg  (ren_preg),
      .rst_en    (rst_en),    .alloc_req (alloc_req),
      .rel_req   (rel_req),   .rel_id    (rel_id),
      .ena       (ena),       .wea       (wea),
      .addra     (addra),     .dina      (dina),
      .addrb     (addrb)
   );

   rename_map u_map (
      .clka        (clka),
      .reset       (reset),
      .ren_en      (ren_en),
      .ren_areg    (ren_areg),
      .ren_preg    (ren_preg),
      .rst_en      (rst_en),
      .restore_row (doutb),      // RAM read feeds the restore
      .map_row     (map_row)
   );

   checkpoint_alloc u_alloc (
      .clka      (clka),
      .reset     (reset),
      .alloc_req (alloc_req),
      .rel_req   (rel_req),
      .rel_id    (rel_id),
      .alloc_id  (alloc_id),
      .full      (full),
      .busy_vec  (busy_vec),
      .free_cnt  (free_cnt)
   );

   checkpoint_ram u_ram (
      .clka  (clka),
      .ena   (ena),
      .wea   (wea),
      .addra (addra),
      .dina  (dina),
      .addrb (addrb),
      .doutb (doutb)
   );

endmodule

// File: bench/rename_sva.sv
module rename_sva (
   input logic clka,
   input logic reset,
   input logic cyc,
   input logic stb,
   input logic ack,
   input logic err
);

   int fail_cnt = 0;   // Number of assertion failures so far

   // A transfer ends with ack or with err, never both
   a_ack_err_excl: assert property (@(posedge clka) disable iff (reset) !(ack && err))
      else begin
         fail_cnt++;
         $error("ack and err high in the same cycle");
      end

   // Each response is a single-cycle pulse
   a_ack_pulse: assert property (@(posedge clka) disable iff (reset) ack |=> !ack)
      else begin
         fail_cnt++;
         $error("ack held high for more than one cycle");
      end
   a_err_pulse: assert property (@(posedge clka) disable iff (reset) err |=> !err)
      else begin
         fail_cnt++;
         $error("err held high for more than one cycle");
      end

   // No response unless the master strobed in the cycle before
   a_after_stb: assert property (@(posedge clka) disable iff (reset)
      (ack || err) |-> $past(cyc && stb))
      else begin
         fail_cnt++;
         $error("response raised without a preceding strobe");
      end

endmodule

bind rename_wb_slave rename_sva sva0 (
   .clka  (clka),
   .reset (reset),
   .cyc   (cyc),
   .stb   (stb),
   .ack   (ack),
   .err   (err)
);

// File: bench/rename_checker.sv
module rename_checker import rename_pkg::*; (
   input logic             clka,
   input logic             reset,
   input logic             cyc,
   input logic             stb,
   input logic             we,
   input logic [ADR_W-1:0] adr,
   input logic [DAT_W-1:0] dat_o,
   input logic             ack,
   input logic             err,
   input logic             exp_err,   // Entry should end with err
   input logic [DAT_W-1:0] exp_rd     // Expected read value when it acks
);

   int mismatch_cnt = 0;    // Wrong dat_o, wrong ack or wrong err
   int silent_cnt   = 0;    // Strobes that got no response in time
   int wait_cnt     = 0;    // Cycles the current strobe has waited

   // Sampled on the rising edge, so DUT outputs are the values settled
   // during the previous cycle
   always @(posedge clka) begin
      if (reset) begin
         wait_cnt = 0;
      end
      else if (ack || err) begin
         wait_cnt = 0;
         if (err !== exp_err) begin
            $display("mismatch err: got %h expected %h (adr %h)", err, exp_err, adr);
            mismatch_cnt++;
         end
         else if (ack !== !exp_err) begin   // Exactly one of the two responses
            $display("mismatch ack: got %h expected %h (adr %h)", ack, !exp_err, adr);
            mismatch_cnt++;
         end
         else if (ack && !we && dat_o !== exp_rd) begin
            $display("mismatch dat_o: got %h expected %h (adr %h)", dat_o, exp_rd, adr);
            mismatch_cnt++;
         end
      end
      else if (cyc && stb) begin
         wait_cnt++;
         if (wait_cnt == 2) begin   // Slave owes a response one cycle after the strobe
            $display("no ack or err came back one cycle after the strobe at adr %h", adr);
            silent_cnt++;
         end
      end
      else begin
         wait_cnt = 0;
      end
   end

endmodule

// File: bench/rename_tb.sv
module rename_tb import rename_pkg::*; ();

   logic        clka = 1'b0;
   logic        reset;
   logic        cyc;
   logic        stb;
   logic        we;
   logic        ack;
   logic        err;
   logic [7:0]  adr;
   logic [15:0] dat_i;
   logic [15:0] dat_o;
   logic        exp_err;
   logic [15:0] exp_rd;

   // Stimulus table, one entry per bus transfer
   logic        tbl_we  [$];
   logic [7:0]  tbl_adr [$];
   logic [15:0] tbl_dat [$];
   logic        tbl_err [$];
   logic [15:0] tbl_rd  [$];

   // Reference state built from the block's rules while the table is filled
   logic [5:0]  map_m  [8];
   logic [5:0]  rows_m [16][8];
   logic        busy_m [16];
   logic [3:0]  last_m;
   logic [5:0]  rnd_preg [6];
   int          seed = 32'h151f115f;

   rename_top dut0 (
      .clka(clka), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
      .dat_i(dat_i), .dat_o(dat_o), .ack(ack), .err(err)
   );

   rename_checker chk0 (
      .clka(clka), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
      .dat_o(dat_o), .ack(ack), .err(err), .exp_err(exp_err), .exp_rd(exp_rd)
   );

   initial begin
      forever #4 clka = ~clka;   // Period of 8
   end

   // Works out the response of one transfer and advances the reference state
   task automatic push_entry(input logic w, input op_t op, input logic [3:0] lo,
                             input logic [15:0] d);
      logic        e_err;
      logic [15:0] e_rd;
      int          id;
      int          nfree;
      e_err = 1'b0;
      e_rd  = '0;
      id    = -1;
      nfree = 0;
      for (int i = 0; i < 16; i++) begin
         if (!busy_m[i]) begin
            nfree++;
            if (id < 0) id = i;   // Lowest free id
         end
      end
      case (op)
         OP_RENAME:  map_m[lo[2:0]] = d[5:0];
         OP_SAVE: begin
            if (id < 0) e_err = 1'b1;   // All rows taken
            else begin
               rows_m[id] = map_m;
               busy_m[id] = 1'b1;
               last_m     = id[3:0];
            end
         end
         OP_PATCH:   rows_m[lo][d[10:8]] = d[5:0];
         OP_RESTORE: begin
            if (!busy_m[lo]) e_err = 1'b1;
            else begin
               map_m      = rows_m[lo];
               busy_m[lo] = 1'b0;
            end
         end
         OP_RELEASE: begin
            if (!busy_m[lo]) e_err = 1'b1;
            else busy_m[lo] = 1'b0;
         end
         OP_MAP:     e_rd = {10'd0, map_m[lo[2:0]]};
         OP_LASTID:  e_rd = {12'd0, last_m};
         OP_FREE:    e_rd = 16'(nfree);
         default:    e_err = 1'b1;    // Op code not defined
      endcase
      tbl_we.push_back(w);
      tbl_adr.push_back({op, lo});
      tbl_dat.push_back(d);
      tbl_err.push_back(e_err);
      tbl_rd.push_back(e_rd);
   endtask

   task automatic write_op(input op_t op, input logic [3:0] lo, input logic [15:0] d);
      push_entry(1'b1, op, lo, d);
   endtask

   task automatic read_op(input op_t op, input logic [3:0] lo);
      push_entry(1'b0, op, lo, 16'd0);
   endtask

   // ============================================================
   // Table contents
   // ============================================================
   task automatic build_table();
      for (int i = 0; i < 8; i++) map_m[i] = 6'(i);   // Identity out of reset
      for (int i = 0; i < 16; i++) begin
         busy_m[i] = 1'b0;
         for (int j = 0; j < 8; j++) rows_m[i][j] = '0;
      end
      last_m = '0;
      for (int i = 0; i < 6; i++) rnd_preg[i] = 6'($random(seed));
      for (int i = 0; i < 8; i++) read_op(OP_MAP, 4'(i));      // Reset map
      read_op(OP_FREE, 0);
      write_op(OP_RENAME, 3, {10'd0, rnd_preg[0]});             // One lane renamed
      for (int i = 0; i < 8; i++) read_op(OP_MAP, 4'(i));
      for (int i = 0; i < 16; i++) begin                        // Fill every row
         write_op(OP_SAVE, 0, 0);
         read_op(OP_LASTID, 0);
      end
      write_op(OP_SAVE, 0, 0);                                  // Full, expect err
      read_op(OP_FREE, 0);
      read_op(OP_LASTID, 0);
      write_op(OP_RELEASE, 5, 0);
      read_op(OP_FREE, 0);
      write_op(OP_RENAME, 3, {10'd0, rnd_preg[5]});             // Map now differs from row 5
      write_op(OP_RELEASE, 5, 0);                               // Already free
      write_op(OP_RESTORE, 5, 0);                               // Not allocated
      write_op(op_t'(4'h7), 3, 16'h00ff);                       // Unknown op
      read_op(OP_FREE, 0);
      read_op(OP_MAP, 3);
      write_op(OP_SAVE, 0, 0);                                  // Reuses id 5
      read_op(OP_LASTID, 0);
      for (int i = 0; i < 3; i++) write_op(OP_RENAME, 4'(i), {10'd0, rnd_preg[i+1]});
      read_op(OP_MAP, 1);
      read_op(OP_FREE, 0);
      write_op(OP_RESTORE, 5, 0);
      read_op(OP_FREE, 0);
      for (int i = 0; i < 8; i++) read_op(OP_MAP, 4'(i));
      write_op(OP_PATCH, 2, {5'd0, 3'd6, 2'd0, rnd_preg[4]});   // Lane 6 of row 2
      write_op(OP_RESTORE, 2, 0);
      for (int i = 0; i < 8; i++) read_op(OP_MAP, 4'(i));
      read_op(OP_FREE, 0);
   endtask

   // ============================================================
   // Main sequence
   // ============================================================
   initial begin
      int waited;
      int total;
      reset   = 1'b1;
      cyc     = 1'b0;
      stb     = 1'b0;
      we      = 1'b0;
      adr     = '0;
      dat_i   = '0;
      exp_err = 1'b0;
      exp_rd  = '0;
      build_table();
      fork
         begin   // Watchdog scaled to the table length
            #((tbl_we.size() * 4 + 100) * 8);
            $display("watchdog expired before the table finished");
            $display("*** FAILED ***");
            $finish;
         end
      join_none
      repeat (8) @(posedge clka);
      reset <= 1'b0;
      for (int k = 0; k < tbl_we.size(); k++) begin
         @(posedge clka);
         cyc     <= 1'b1;
         stb     <= 1'b1;
         we      <= tbl_we[k];
         adr     <= tbl_adr[k];
         dat_i   <= tbl_dat[k];
         exp_err <= tbl_err[k];
         exp_rd  <= tbl_rd[k];
         waited = 0;
         @(posedge clka);
         while (!(ack || err) && waited < 4) begin   // Checker flags a missing response
            @(posedge clka);
            waited++;
         end
         cyc <= 1'b0;
         stb <= 1'b0;
      end
      repeat (2) @(posedge clka);
      total = chk0.mismatch_cnt + chk0.silent_cnt + dut0.u_slave.sva0.fail_cnt;
      $display("errors: %0d mismatch, %0d missing response, %0d assertion, %0d total",
               chk0.mismatch_cnt, chk0.silent_cnt, dut0.u_slave.sva0.fail_cnt, total);
      if (total == 0) begin
         $display("*** PASSED ***");
      end
      else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// File: filelist.f
rtl/rename_pkg.sv
rtl/checkpoint_ram.sv
rtl/rename_map.sv
rtl/checkpoint_alloc.sv
rtl/rename_wb_slave.sv
rtl/rename_top.sv
bench/rename_sva.sv
bench/rename_checker.sv
bench/rename_tb.sv
